/* common/miller_pkg.sv */
/*
  Shared definitions for the Miller loop engine
  - Field element width and type
  - Multiplier client tags
  - Modular add and subtract helpers
*/

package miller_pkg;

  localparam int FP_BITS = 16;

  typedef logic [FP_BITS-1:0] fp_t;
  typedef logic [1:0]         req_tag_t;

  // Tag value doubles as the bit index in request and grant vectors
  localparam req_tag_t TAG_DBL  = 2'd0;
  localparam req_tag_t TAG_ADD  = 2'd1;
  localparam req_tag_t TAG_LOOP = 2'd2;

  // a + b mod p, one conditional subtract
  function automatic fp_t fp_add(fp_t a, fp_t b, fp_t p);
    logic [FP_BITS:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, p})
      s = s - {1'b0, p};
    return s[FP_BITS-1:0];
  endfunction

  // a - b mod p, wraps through p on borrow
  function automatic fp_t fp_sub(fp_t a, fp_t b, fp_t p);
    logic [FP_BITS:0] d;
    if (a >= b)
      d = {1'b0, a} - {1'b0, b};
    else
      d = {1'b0, a} + {1'b0, p} - {1'b0, b};
    return d[FP_BITS-1:0];
  endfunction

endpackage

/* design/fp_mul.sv */
/*
  Pipelined modular multiplier over Fp
  Stage 1 registers operands, stage 2 forms the full product,
  stage 3 reduces it. Valid and tag travel with the data.
*/
`timescale 1ns/1ns

module fp_mul
  import miller_pkg::*;
#(
  parameter fp_t P_MOD = 16'd65521
)(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_val,
  input  fp_t      i_a,
  input  fp_t      i_b,
  input  req_tag_t i_tag,
  output logic     o_val,
  output fp_t      o_p,
  output req_tag_t o_tag
);

  fp_t                  s1_a, s1_b;
  logic [2*FP_BITS-1:0] s2_prod;
  logic                 s1_val, s2_val;
  req_tag_t             s1_tag, s2_tag;

  // Valid chain
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
      o_val  <= 1'b0;
    end else begin
      s1_val <= i_val;
      s2_val <= s1_val;
      o_val  <= s2_val;
    end
  end

  always_ff @(posedge i_clk) begin
    s1_a    <= i_a;
    s1_b    <= i_b;
    s1_tag  <= i_tag;
    s2_prod <= s1_a * s1_b;                  // Full 32-bit product
    s2_tag  <= s1_tag;
    o_p     <= fp_t'(s2_prod % 32'(P_MOD));  // Reduce into [0, P_MOD)
    o_tag   <= s2_tag;
  end

endmodule

/* design/mul_share.sv */
/*
  Shared multiplier front end
  - Fixed priority grant: loop, then doubling, then addition
  - Drives the winner's operands and tag into fp_mul
  - Decodes the returning tag into per-client result strobes
*/
`timescale 1ns/1ns

module mul_share
  import miller_pkg::*;
#(
  parameter fp_t P_MOD = 16'd65521
)(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic [2:0] i_req,
  input  fp_t        i_a_dbl,
  input  fp_t        i_b_dbl,
  input  fp_t        i_a_add,
  input  fp_t        i_b_add,
  input  fp_t        i_a_loop,
  input  fp_t        i_b_loop,
  output logic [2:0] o_gnt,
  output logic [2:0] o_res_val,
  output fp_t        o_res
);

  fp_t      mul_a, mul_b, mul_p;
  req_tag_t mul_tag, res_tag;
  logic     mul_val, res_val;

  // Grant in the same cycle as the request
  always_comb begin
    o_gnt   = '0;
    mul_tag = TAG_DBL;
    mul_a   = i_a_dbl;
    mul_b   = i_b_dbl;
    if (i_req[TAG_LOOP]) begin
      o_gnt[TAG_LOOP] = 1'b1;
      mul_tag         = TAG_LOOP;
      mul_a           = i_a_loop;
      mul_b           = i_b_loop;
    end else if (i_req[TAG_DBL]) begin
      o_gnt[TAG_DBL] = 1'b1;
    end else if (i_req[TAG_ADD]) begin
      o_gnt[TAG_ADD] = 1'b1;
      mul_tag        = TAG_ADD;
      mul_a          = i_a_add;
      mul_b          = i_b_add;
    end
  end

  assign mul_val = |i_req;

  fp_mul #(.P_MOD(P_MOD)) fp_mul_i (
    .i_clk (i_clk),   .i_rst (i_rst),
    .i_val (mul_val), .i_a   (mul_a),   .i_b (mul_b), .i_tag (mul_tag),
    .o_val (res_val), .o_p   (mul_p),   .o_tag (res_tag)
  );

  // Product goes to everyone, only the owner sees its strobe
  always_comb begin
    o_res_val = '0;
    if (res_val)
      o_res_val[res_tag] = 1'b1;
  end

  assign o_res = mul_p;

endmodule

/* miller/miller_dbl.sv */
/*
  Doubling step of the Miller loop
  Homogeneous doubling of T for y^2 = x^3 + b, plus the tangent
  line evaluated at P. All products go through the shared multiplier,
  independent ones are issued back to back.
*/
`timescale 1ns/1ns

module miller_dbl
  import miller_pkg::*;
#(
  parameter fp_t P_MOD = 16'd65521
)(
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_start,
  input  fp_t  i_x, i_y, i_z,
  input  fp_t  i_xp, i_yp,
  output logic o_req,
  input  logic i_gnt,
  input  logic i_res_val,
  output fp_t  o_a, o_b,
  input  fp_t  i_res,
  output logic o_done,
  output fp_t  o_x, o_y, o_z, o_l
);

  localparam int N_OPS = 15;

  fp_t        x_r, y_r, z_r, xp_r, yp_r;
  fp_t        r [0:N_OPS-1];   // Products in issue order
  fp_t        w, b4, h;
  logic [3:0] iss, ret, need;
  logic       busy, fin;

  function automatic fp_t mul2(fp_t v);
    return fp_add(v, v, P_MOD);
  endfunction

  assign w   = fp_add(mul2(r[0]), r[0], P_MOD);  // 3 X^2
  assign b4  = mul2(mul2(r[7]));
  assign h   = fp_sub(r[6], mul2(b4), P_MOD);    // W^2 - 8B
  assign fin = busy && (ret == 4'(N_OPS));

  // Operand table, need is the result count an op waits for
  always_comb begin
    need = '0;
    o_a  = '0;
    o_b  = '0;
    case (iss)
      4'd0:  begin o_a = x_r;  o_b = x_r; end
      4'd1:  begin o_a = y_r;  o_b = z_r; end          // S
      4'd2:  begin o_a = x_r;  o_b = y_r; end
      4'd3:  begin o_a = y_r;  o_b = y_r; end
      4'd4:  begin o_a = yp_r; o_b = z_r; end
      4'd5:  begin o_a = xp_r; o_b = z_r; end
      4'd6:  begin need = 4'd1; o_a = w;    o_b = w;    end
      4'd7:  begin need = 4'd3; o_a = r[2]; o_b = r[1]; end  // B
      4'd8:  begin need = 4'd2; o_a = r[1]; o_b = r[1]; end
      4'd9:  begin need = 4'd5; o_a = r[1]; o_b = fp_sub(r[4], y_r, P_MOD); end
      4'd10: begin need = 4'd6; o_a = w;    o_b = fp_sub(r[5], x_r, P_MOD); end
      4'd11: begin need = 4'd8; o_a = h;    o_b = r[1]; end
      4'd12: begin need = 4'd8; o_a = w;    o_b = fp_sub(b4, h, P_MOD); end
      4'd13: begin need = 4'd9; o_a = r[3]; o_b = r[8]; end  // Y^2 S^2
      4'd14: begin need = 4'd9; o_a = r[8]; o_b = r[1]; end  // S^3
      default: ;
    endcase
  end

  assign o_req = busy && (iss < 4'(N_OPS)) && (ret >= need);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      o_done <= 1'b0;
      iss    <= '0;
      ret    <= '0;
    end else begin
      o_done <= fin;
      if (i_start && !busy) begin
        busy <= 1'b1;
        iss  <= '0;
        ret  <= '0;
      end else if (fin) begin
        busy <= 1'b0;
      end else begin
        if (o_req && i_gnt) iss <= iss + 4'd1;
        if (i_res_val)      ret <= ret + 4'd1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start && !busy) begin
      x_r  <= i_x;
      y_r  <= i_y;
      z_r  <= i_z;
      xp_r <= i_xp;
      yp_r <= i_yp;
    end
    if (busy && i_res_val)
      r[ret] <= i_res;
    if (fin) begin
      o_x <= mul2(r[11]);                                   // 2 H S
      o_y <= fp_sub(r[12], mul2(mul2(mul2(r[13]))), P_MOD);
      o_z <= mul2(mul2(mul2(r[14])));                       // 8 S^3
      o_l <= fp_sub(mul2(r[9]), r[10], P_MOD);
    end
  end

endmodule

/* miller/miller_add.sv */
/*
  Addition step of the Miller loop
  Mixed addition of projective T with affine Q, plus the chord
  line evaluated at P, through the shared multiplier.
*/
`timescale 1ns/1ns

module miller_add
  import miller_pkg::*;
#(
  parameter fp_t P_MOD = 16'd65521
)(
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_start,
  input  fp_t  i_x, i_y, i_z,
  input  fp_t  i_xp, i_yp,
  input  fp_t  i_xq, i_yq,
  output logic o_req,
  input  logic i_gnt,
  input  logic i_res_val,
  output fp_t  o_a, o_b,
  input  fp_t  i_res,
  output logic o_done,
  output fp_t  o_x, o_y, o_z, o_l
);

  localparam int N_OPS = 13;

  fp_t        x_r, y_r, z_r, xp_r, yp_r, xq_r, yq_r;
  fp_t        r [0:N_OPS-1];
  fp_t        u, v, big_a;
  logic [3:0] iss, ret, need;
  logic       busy, fin;

  assign u     = fp_sub(r[0], y_r, P_MOD);   // yQ Z - Y
  assign v     = fp_sub(r[1], x_r, P_MOD);   // xQ Z - X
  assign big_a = fp_sub(fp_sub(r[6], r[7], P_MOD), fp_add(r[8], r[8], P_MOD), P_MOD);
  assign fin   = busy && (ret == 4'(N_OPS));

  always_comb begin
    need = '0;
    o_a  = '0;
    o_b  = '0;
    case (iss)
      4'd0:  begin o_a = yq_r; o_b = z_r; end
      4'd1:  begin o_a = xq_r; o_b = z_r; end
      4'd2:  begin need = 4'd1; o_a = u;    o_b = u;    end
      4'd3:  begin need = 4'd2; o_a = v;    o_b = v;    end
      4'd4:  begin need = 4'd1; o_a = u;    o_b = fp_sub(xp_r, xq_r, P_MOD); end
      4'd5:  begin need = 4'd2; o_a = v;    o_b = fp_sub(yp_r, yq_r, P_MOD); end
      4'd6:  begin need = 4'd3; o_a = r[2]; o_b = z_r;  end  // u^2 Z
      4'd7:  begin need = 4'd4; o_a = r[3]; o_b = v;    end  // v^3
      4'd8:  begin need = 4'd4; o_a = r[3]; o_b = x_r;  end  // v^2 X
      4'd9:  begin need = 4'd8; o_a = r[7]; o_b = z_r;  end
      4'd10: begin need = 4'd8; o_a = r[7]; o_b = y_r;  end
      4'd11: begin need = 4'd9; o_a = v;    o_b = big_a; end
      4'd12: begin need = 4'd9; o_a = u;    o_b = fp_sub(r[8], big_a, P_MOD); end
      default: ;
    endcase
  end

  assign o_req = busy && (iss < 4'(N_OPS)) && (ret >= need);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy   <= 1'b0;
      o_done <= 1'b0;
      iss    <= '0;
      ret    <= '0;
    end else begin
      o_done <= fin;
      if (i_start && !busy) begin
        busy <= 1'b1;
        iss  <= '0;
        ret  <= '0;
      end else if (fin) begin
        busy <= 1'b0;
      end else begin
        if (o_req && i_gnt) iss <= iss + 4'd1;
        if (i_res_val)      ret <= ret + 4'd1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_start && !busy) begin
      x_r  <= i_x;
      y_r  <= i_y;
      z_r  <= i_z;
      xp_r <= i_xp;
      yp_r <= i_yp;
      xq_r <= i_xq;
      yq_r <= i_yq;
    end
    if (busy && i_res_val)
      r[ret] <= i_res;
    if (fin) begin
      o_x <= r[11];                        // v A
      o_y <= fp_sub(r[12], r[10], P_MOD);
      o_z <= r[9];                         // v^3 Z
      o_l <= fp_sub(r[4], r[5], P_MOD);
    end
  end

endmodule

/* miller/miller_loop.sv */
/*
  Miller loop controller
  - Walks LOOP_X from bit LOOP_LEN-2 down to 0
  - Squares f while the doubling step runs
  - Folds in tangent and, for set bits, chord line values
  - Holds the result register o_f
*/
`timescale 1ns/1ns

module miller_loop
  import miller_pkg::*;
#(
  parameter int                  LOOP_LEN = 6,
  parameter logic [LOOP_LEN-1:0] LOOP_X   = 6'b110101
)(
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_start,
  input  fp_t  i_xp, i_yp, i_xq, i_yq,
  output logic o_busy,
  output logic o_done,
  output fp_t  o_f,
  // Step modules
  output logic o_dbl_start,
  input  logic i_dbl_done,
  output logic o_add_start,
  input  logic i_add_done,
  output fp_t  o_tx, o_ty, o_tz,
  output fp_t  o_xp, o_yp, o_xq, o_yq,
  input  fp_t  i_dbl_x, i_dbl_y, i_dbl_z, i_dbl_l,
  input  fp_t  i_add_x, i_add_y, i_add_z, i_add_l,
  // Shared multiplier
  output logic o_req,
  input  logic i_gnt,
  output fp_t  o_a, o_b,
  input  logic i_res_val,
  input  fp_t  i_res
);

  localparam int IDX_W = $clog2(LOOP_LEN);

  typedef enum logic [2:0] {ST_IDLE, ST_BIT, ST_DBL, ST_TAN, ST_CHD, ST_END} state_t;

  state_t           state;
  logic [IDX_W-1:0] idx;
  logic             cur_bit;
  logic             dbl_ok, sq_ok, add_ok, mul_ok;
  fp_t              f, l_tan, l_chd;

  assign cur_bit = LOOP_X[idx];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state       <= ST_IDLE;
      idx         <= '0;
      o_busy      <= 1'b0;
      o_done      <= 1'b0;
      o_req       <= 1'b0;
      o_dbl_start <= 1'b0;
      o_add_start <= 1'b0;
      dbl_ok      <= 1'b0;
      sq_ok       <= 1'b0;
      add_ok      <= 1'b0;
      mul_ok      <= 1'b0;
    end else begin
      o_done      <= 1'b0;
      o_dbl_start <= 1'b0;
      o_add_start <= 1'b0;
      if (o_req && i_gnt) o_req <= 1'b0;   // Request held until granted
      case (state)
        ST_IDLE: if (i_start && !o_busy) begin
          o_busy <= 1'b1;
          o_xp   <= i_xp;
          o_yp   <= i_yp;
          o_xq   <= i_xq;
          o_yq   <= i_yq;
          o_tx   <= i_xq;                   // T = Q, Z = 1
          o_ty   <= i_yq;
          o_tz   <= fp_t'(1);
          f      <= fp_t'(1);
          idx    <= IDX_W'(LOOP_LEN - 2);
          state  <= ST_BIT;
        end
        ST_BIT: begin
          o_dbl_start <= 1'b1;
          o_req       <= 1'b1;             // f^2 alongside the doubling
          o_a         <= f;
          o_b         <= f;
          state       <= ST_DBL;
        end
        ST_DBL: begin
          if (i_dbl_done) begin
            o_tx   <= i_dbl_x;
            o_ty   <= i_dbl_y;
            o_tz   <= i_dbl_z;
            l_tan  <= i_dbl_l;
            dbl_ok <= 1'b1;
          end
          if (i_res_val) begin
            f     <= i_res;
            sq_ok <= 1'b1;
          end
          if (dbl_ok && sq_ok) begin
            dbl_ok      <= 1'b0;
            sq_ok       <= 1'b0;
            o_req       <= 1'b1;
            o_a         <= f;
            o_b         <= l_tan;
            o_add_start <= cur_bit;        // Addition overlaps f * l_tan
            state       <= ST_TAN;
          end
        end
        ST_TAN: begin
          if (i_add_done) begin
            o_tx   <= i_add_x;
            o_ty   <= i_add_y;
            o_tz   <= i_add_z;
            l_chd  <= i_add_l;
            add_ok <= 1'b1;
          end
          if (i_res_val) begin
            f      <= i_res;
            mul_ok <= 1'b1;
          end
          if (mul_ok && (add_ok || !cur_bit)) begin
            mul_ok <= 1'b0;
            add_ok <= 1'b0;
            if (cur_bit) begin
              o_req <= 1'b1;
              o_a   <= f;
              o_b   <= l_chd;
              state <= ST_CHD;
            end else begin
              state <= ST_END;
            end
          end
        end
        ST_CHD: if (i_res_val) begin
          f     <= i_res;
          state <= ST_END;
        end
        ST_END: begin
          if (idx == '0) begin
            o_f    <= f;                   // Result register, held until next done
            o_done <= 1'b1;
            o_busy <= 1'b0;
            state  <= ST_IDLE;
          end else begin
            idx   <= idx - 1'b1;
            state <= ST_BIT;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* design/pairing_top.sv */
/*
  Top level of the reduced Miller loop engine
  Loop controller, doubling and addition steps, and the
  arbiter in front of the shared modular multiplier
*/
`timescale 1ns/1ns

module pairing_top
  import miller_pkg::*;
#(
  parameter fp_t                 P_MOD    = 16'd65521,
  parameter int                  LOOP_LEN = 6,
  parameter logic [LOOP_LEN-1:0] LOOP_X   = 6'b110101
)(
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_start,
  input  fp_t  i_xp, i_yp, i_xq, i_yq,
  output logic o_busy,
  output logic o_done,
  output fp_t  o_f
);

  logic [2:0] req, gnt, res_val;   // Indexed by client tag
  logic       dbl_start, dbl_done, add_start, add_done;
  fp_t        tx, ty, tz, xp, yp, xq, yq, res;
  fp_t        dbl_x, dbl_y, dbl_z, dbl_l, add_x, add_y, add_z, add_l;
  fp_t        a_dbl, b_dbl, a_add, b_add, a_loop, b_loop;

  miller_loop #(.LOOP_LEN(LOOP_LEN), .LOOP_X(LOOP_X)) miller_loop_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_start (i_start),
    .i_xp (i_xp), .i_yp (i_yp), .i_xq (i_xq), .i_yq (i_yq),
    .o_busy (o_busy), .o_done (o_done), .o_f (o_f),
    .o_dbl_start (dbl_start), .i_dbl_done (dbl_done),
    .o_add_start (add_start), .i_add_done (add_done),
    .o_tx (tx), .o_ty (ty), .o_tz (tz),
    .o_xp (xp), .o_yp (yp), .o_xq (xq), .o_yq (yq),
    .i_dbl_x (dbl_x), .i_dbl_y (dbl_y), .i_dbl_z (dbl_z), .i_dbl_l (dbl_l),
    .i_add_x (add_x), .i_add_y (add_y), .i_add_z (add_z), .i_add_l (add_l),
    .o_req (req[TAG_LOOP]), .i_gnt (gnt[TAG_LOOP]), .o_a (a_loop), .o_b (b_loop),
    .i_res_val (res_val[TAG_LOOP]), .i_res (res)
  );

  miller_dbl #(.P_MOD(P_MOD)) miller_dbl_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_start (dbl_start),
    .i_x (tx), .i_y (ty), .i_z (tz), .i_xp (xp), .i_yp (yp),
    .o_req (req[TAG_DBL]), .i_gnt (gnt[TAG_DBL]), .i_res_val (res_val[TAG_DBL]),
    .o_a (a_dbl), .o_b (b_dbl), .i_res (res),
    .o_done (dbl_done), .o_x (dbl_x), .o_y (dbl_y), .o_z (dbl_z), .o_l (dbl_l)
  );

  miller_add #(.P_MOD(P_MOD)) miller_add_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_start (add_start),
    .i_x (tx), .i_y (ty), .i_z (tz), .i_xp (xp), .i_yp (yp), .i_xq (xq), .i_yq (yq),
    .o_req (req[TAG_ADD]), .i_gnt (gnt[TAG_ADD]), .i_res_val (res_val[TAG_ADD]),
    .o_a (a_add), .o_b (b_add), .i_res (res),
    .o_done (add_done), .o_x (add_x), .o_y (add_y), .o_z (add_z), .o_l (add_l)
  );

  mul_share #(.P_MOD(P_MOD)) mul_share_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_req (req),
    .i_a_dbl (a_dbl), .i_b_dbl (b_dbl), .i_a_add (a_add), .i_b_add (b_add),
    .i_a_loop (a_loop), .i_b_loop (b_loop),
    .o_gnt (gnt), .o_res_val (res_val), .o_res (res)
  );

endmodule

/* test/pairing_assert.sv */
/*
  Concurrent protocol assertions
  - Done strobe lasts one cycle
  - At most one multiplier grant per cycle
  - Every grant has a matching request
*/
`timescale 1ns/1ns

module pairing_assert (
  input logic       i_clk,
  input logic       i_rst,
  input logic       i_done,
  input logic [2:0] i_req,
  input logic [2:0] i_gnt
);

  done_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst) i_done |=> !i_done)
    else $error("done strobe longer than one cycle");

  one_grant: assert property (@(posedge i_clk) disable iff (i_rst) $onehot0(i_gnt))
    else $error("more than one grant");

  grant_has_req: assert property (@(posedge i_clk) disable iff (i_rst) (i_gnt & ~i_req) == 3'b000)
    else $error("grant without request");

endmodule

bind miller_loop pairing_assert loop_chk_i (
  .i_clk (i_clk), .i_rst (i_rst), .i_done (o_done),
  .i_req ({2'b00, o_req}), .i_gnt ({2'b00, i_gnt})   // Loop client only
);

bind mul_share pairing_assert share_chk_i (
  .i_clk (i_clk), .i_rst (i_rst), .i_done (1'b0),
  .i_req (i_req), .i_gnt (o_gnt)
);

/* test/tb_pairing.sv */
/*
  Testbench for the reduced Miller loop engine
  - Clock, reset and falling edge stimulus
  - Reference model of the loop in 32-bit modular arithmetic
  - Directed tests: reset state, known points, zero coordinate,
    start while busy, random points, back-to-back runs
  - Protocol monitor on done and multiplier grants
*/
`timescale 1ns/1ns

module tb_pairing
  import miller_pkg::*;
();

  localparam fp_t                 P_MOD        = 16'd65521;
  localparam int                  LOOP_LEN     = 6;
  localparam logic [LOOP_LEN-1:0] LOOP_X       = 6'b110101;
  localparam logic [31:0]         PM           = 32'(P_MOD);
  localparam int                  DONE_TIMEOUT = 4000;

  logic i_clk, i_rst, i_start;
  fp_t  i_xp, i_yp, i_xq, i_yq;
  logic o_busy, o_done;
  fp_t  o_f;

  int   errors = 0;
  int   tests  = 0;
  logic done_q = 1'b0;

  pairing_top #(.P_MOD(P_MOD), .LOOP_LEN(LOOP_LEN), .LOOP_X(LOOP_X)) dut_i (
    .i_clk (i_clk), .i_rst (i_rst), .i_start (i_start),
    .i_xp (i_xp), .i_yp (i_yp), .i_xq (i_xq), .i_yq (i_yq),
    .o_busy (o_busy), .o_done (o_done), .o_f (o_f)
  );

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk;   // 40 ns period

  // Done is a single cycle strobe, at most one grant, grant only on request
  always @(negedge i_clk) begin
    if (!i_rst) begin
      assert ($onehot0(dut_i.gnt)) else begin
        $display("More than one multiplier grant at %0t", $time);
        errors++;
      end
      assert ((dut_i.gnt & ~dut_i.req) == 3'b000) else begin
        $display("Multiplier grant without a request at %0t", $time);
        errors++;
      end
      assert (!(o_done && done_q)) else begin
        $display("o_done stayed high for more than one cycle at %0t", $time);
        errors++;
      end
    end
    done_q = o_done;
  end

  function automatic logic [31:0] mulm(logic [31:0] a, logic [31:0] b);
    return (a * b) % PM;
  endfunction

  function automatic logic [31:0] subm(logic [31:0] a, logic [31:0] b);
    return (a + PM - b) % PM;
  endfunction

  // Loop over the scalar with homogeneous doubling and mixed addition
  function automatic fp_t model_f(fp_t xp_in, fp_t yp_in, fp_t xq_in, fp_t yq_in);
    logic [31:0] xp, yp, xq, yq, x, y, z, f;
    logic [31:0] w, s, bb, h, l, nx, ny, nz, u, v, v2, v3, a;
    int          i;
    xp = 32'(xp_in);
    yp = 32'(yp_in);
    xq = 32'(xq_in);
    yq = 32'(yq_in);
    x  = xq;
    y  = yq;
    z  = 32'd1;
    f  = 32'd1;
    for (i = LOOP_LEN - 2; i >= 0; i--) begin
      w  = mulm(32'd3, mulm(x, x));
      s  = mulm(y, z);
      bb = mulm(mulm(x, y), s);
      h  = subm(mulm(w, w), mulm(32'd8, bb));
      l  = subm(mulm(mulm(32'd2, s), subm(mulm(yp, z), y)), mulm(w, subm(mulm(xp, z), x)));
      nx = mulm(mulm(32'd2, h), s);
      ny = subm(mulm(w, subm(mulm(32'd4, bb), h)),
                mulm(32'd8, mulm(mulm(y, y), mulm(s, s))));
      nz = mulm(32'd8, mulm(s, mulm(s, s)));
      f  = mulm(mulm(f, f), l);
      x  = nx;
      y  = ny;
      z  = nz;
      if (LOOP_X[i]) begin
        u  = subm(mulm(yq, z), y);
        v  = subm(mulm(xq, z), x);
        v2 = mulm(v, v);
        v3 = mulm(v2, v);
        a  = subm(subm(mulm(mulm(u, u), z), v3), mulm(32'd2, mulm(v2, x)));
        l  = subm(mulm(u, subm(xp, xq)), mulm(v, subm(yp, yq)));
        nx = mulm(v, a);
        ny = subm(mulm(u, subm(mulm(v2, x), a)), mulm(v3, y));
        nz = mulm(v3, z);
        f  = mulm(f, l);
        x  = nx;
        y  = ny;
        z  = nz;
      end
    end
    return fp_t'(f);
  endfunction

  task automatic start_run(input fp_t xp, input fp_t yp, input fp_t xq, input fp_t yq);
    @(negedge i_clk);
    i_xp    = xp;
    i_yp    = yp;
    i_xq    = xq;
    i_yq    = yq;
    i_start = 1'b1;
    @(negedge i_clk);
    i_start = 1'b0;
  endtask

  task automatic check_value(input string what, input fp_t got, input fp_t exp_val);
    assert (got === exp_val) else begin
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp_val);
      errors++;
    end
  endtask

  // Returns on the falling edge where o_done is seen
  task automatic wait_done(input bit check_busy, input bit check_hold, input fp_t hold_val,
                           output bit seen);
    int n;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < DONE_TIMEOUT) begin
      @(negedge i_clk);
      n++;
      if (o_done) begin
        seen = 1'b1;
        assert (o_busy === 1'b0) else begin
          $display("Fail %0t: o_busy still high with o_done", $time);
          errors++;
        end
      end else begin
        if (check_busy)
          assert (o_busy === 1'b1) else begin
            $display("Fail %0t: o_busy low before o_done", $time);
            errors++;
          end
        if (check_hold)
          check_value("o_f before done", o_f, hold_val);
      end
    end
    if (!seen) begin
      $display("Timeout: o_done did not arrive within %0d cycles", DONE_TIMEOUT);
      errors++;
    end
  endtask

  task automatic check_run(input fp_t xp, input fp_t yp, input fp_t xq, input fp_t yq);
    bit seen;
    start_run(xp, yp, xq, yq);
    wait_done(1'b1, 1'b0, '0, seen);
    if (seen)
      check_value("o_f", o_f, model_f(xp, yp, xq, yq));
  endtask

  task automatic report(input string name, input int err0);
    tests++;
    $display("Test %s finished, %0d errors", name, errors - err0);
  endtask

  task automatic test_reset_state();
    int err0;
    err0 = errors;
    repeat (8) begin
      @(negedge i_clk);
      assert (o_busy === 1'b0 && o_done === 1'b0) else begin
        $display("Fail %0t: busy or done high during reset", $time);
        errors++;
      end
    end
    i_rst = 1'b0;
    repeat (4) begin
      @(negedge i_clk);
      assert (o_busy === 1'b0 && o_done === 1'b0) else begin
        $display("Fail %0t: busy or done high before first start", $time);
        errors++;
      end
    end
    report("reset_state", err0);
  endtask

  task automatic test_known_points();
    int err0;
    err0 = errors;
    check_run(16'd5, 16'd12, 16'd17, 16'd40321);
    report("known_points", err0);
  endtask

  task automatic test_zero_coordinate();
    int err0;
    err0 = errors;
    check_run(16'd100, 16'd200, 16'd3, 16'd0);    // yQ = 0
    report("zero_coordinate", err0);
  endtask

  task automatic test_start_while_busy();
    int  err0;
    int  n;
    bit  seen;
    fp_t exp_val;
    err0    = errors;
    exp_val = model_f(16'd1234, 16'd4321, 16'd777, 16'd999);
    start_run(16'd1234, 16'd4321, 16'd777, 16'd999);
    repeat (30) @(negedge i_clk);
    assert (o_busy === 1'b1) else begin
      $display("Fail %0t: run already over before the second start", $time);
      errors++;
    end
    start_run(16'd11, 16'd22, 16'd33, 16'd44);   // Must be ignored
    wait_done(1'b1, 1'b0, '0, seen);
    if (seen)
      check_value("o_f after ignored start", o_f, exp_val);
    for (n = 0; n < 400; n++) begin
      @(negedge i_clk);
      assert (o_done !== 1'b1) else begin
        $display("A second o_done followed a start issued while busy, at %0t", $time);
        errors++;
      end
    end
    report("start_while_busy", err0);
  endtask

  task automatic test_random_points();
    int  err0;
    int  k;
    fp_t rx, ry, qx, qy;
    err0 = errors;
    for (k = 0; k < 20; k++) begin
      rx = fp_t'($urandom % PM);
      ry = fp_t'($urandom % PM);
      qx = fp_t'($urandom % PM);
      qy = fp_t'($urandom % PM);
      check_run(rx, ry, qx, qy);
    end
    report("random_points", err0);
  endtask

  task automatic test_back_to_back();
    int  err0;
    bit  seen;
    fp_t exp_a, exp_b;
    err0  = errors;
    exp_a = model_f(16'd40000, 16'd123, 16'd9, 16'd65000);
    exp_b = model_f(16'd2, 16'd3, 16'd5, 16'd7);
    start_run(16'd40000, 16'd123, 16'd9, 16'd65000);
    wait_done(1'b1, 1'b0, '0, seen);
    if (seen) begin
      check_value("o_f first run", o_f, exp_a);
      start_run(16'd2, 16'd3, 16'd5, 16'd7);      // Cycle right after done
      wait_done(1'b1, 1'b1, exp_a, seen);
      if (seen)
        check_value("o_f second run", o_f, exp_b);
    end
    report("back_to_back", err0);
  endtask

  initial begin
    i_rst   = 1'b1;
    i_start = 1'b0;
    i_xp    = '0;
    i_yp    = '0;
    i_xq    = '0;
    i_yq    = '0;
    void'($urandom(32'ha97a_c0bf));

    test_reset_state();
    test_known_points();
    test_zero_coordinate();
    test_start_while_busy();
    test_random_points();
    test_back_to_back();

    $display("Tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sources.f */
common/miller_pkg.sv
design/fp_mul.sv
design/mul_share.sv
miller/miller_dbl.sv
miller/miller_add.sv
miller/miller_loop.sv
design/pairing_top.sv
test/pairing_assert.sv
test/tb_pairing.sv

/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP      := tb_pairing
FILELIST := sources.f
OBJDIR   := obj_dir
PASS_MSG := Finished with no errors

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
